// File: hdl/idPkg.sv
`default_nettype none

package idPkg;

  // register and pc width for rv64
  typedef logic [63:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  regAddr_t;

  // major opcodes of the base integer set except system
  typedef enum logic [6:0] {
    opLoad    = 7'b0000011,
    opOpImm   = 7'b0010011,
    opAuipc   = 7'b0010111,
    opOpImm32 = 7'b0011011,
    opStore   = 7'b0100011,
    opOp      = 7'b0110011,
    opLui     = 7'b0110111,
    opOp32    = 7'b0111011,
    opBranch  = 7'b1100011,
    opJalr    = 7'b1100111,
    opJal     = 7'b1101111
  } opcode_t;

  // instruction formats
  typedef enum logic [2:0] {
    typeR   = 3'd0,
    typeI   = 3'd1,
    typeS   = 3'd2,
    typeB   = 3'd3,
    typeU   = 3'd4,
    typeJ   = 3'd5,
    typeBad = 3'd6
  } instType_t;

  // operation code seen by the execute stage
  typedef enum logic [4:0] {
    aluAdd  = 5'd0,
    aluSub  = 5'd1,
    aluSll  = 5'd2,
    aluSllw = 5'd3,
    aluSlt  = 5'd4,
    aluSltu = 5'd5,
    aluXor  = 5'd6,
    aluSrl  = 5'd7,
    aluSra  = 5'd8,
    aluOr   = 5'd9,
    aluAnd  = 5'd10
  } aluOp_t;

  // next-pc request kind
  typedef enum logic [3:0] {
    jumpNone   = 4'd0,
    jumpJal    = 4'd1,
    jumpJalr   = 4'd2,
    jumpBranch = 4'd3
  } jumpKind_t;

endpackage

`default_nettype wire

// File: hdl/instDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instDecode import idPkg::*; (
  input  logic      clock,
  input  logic      rstN,
  input  inst_t     inst,
  output regAddr_t  rs1,
  output regAddr_t  rs2,
  output regAddr_t  rd,
  output opcode_t   opcode,
  output instType_t instType,
  output word_t     imm,
  output aluOp_t    aluOp,
  output logic [2:0] func3,
  output logic      wen,
  output logic      readFlag,
  output logic      writeFlag,
  output logic      jalrFlag,
  output logic      wordOp,
  output logic      abort,
  output logic [7:0] wmask
);

  logic [6:0] func7;

  assign opcode = opcode_t'(inst[6:0]);
  assign func3  = inst[14:12];
  assign func7  = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  // format from major opcode
  always_comb begin
    case (opcode)
      opOp, opOp32:                          instType = typeR;
      opLoad, opOpImm, opOpImm32, opJalr:    instType = typeI;
      opStore:                               instType = typeS;
      opLui, opAuipc:                        instType = typeU;
      opJal:                                 instType = typeJ;
      opBranch:                              instType = typeB;
      default:                               instType = typeBad;
    endcase
  end

  // sign-extended immediate per format
  always_comb begin
    case (instType)
      typeI:   imm = {{52{inst[31]}}, inst[31:20]};
      typeS:   imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      typeB:   imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      typeU:   imm = {{32{inst[31]}}, inst[31:12], 12'b0};
      typeJ:   imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  always_comb begin
    aluOp = aluAdd;
    case (opcode)
      opOpImm: begin
        case (func3)
          3'b001:  aluOp = aluSll;
          3'b010:  aluOp = aluSlt;
          3'b011:  aluOp = aluSltu;
          3'b100:  aluOp = aluXor;
          // bit 30 picks arithmetic shift
          3'b101:  aluOp = inst[30] ? aluSra : aluSrl;
          3'b110:  aluOp = aluOr;
          3'b111:  aluOp = aluAnd;
          default: aluOp = aluAdd;
        endcase
      end
      opOpImm32: begin
        case (func3)
          3'b001:  aluOp = aluSllw;
          3'b101:  aluOp = inst[30] ? aluSra : aluSrl;
          default: aluOp = aluAdd;
        endcase
      end
      opOp: begin
        case ({func7, func3})
          {7'b0100000, 3'b000}: aluOp = aluSub;
          {7'b0000000, 3'b001}: aluOp = aluSll;
          {7'b0000000, 3'b010}: aluOp = aluSlt;
          {7'b0000000, 3'b011}: aluOp = aluSltu;
          {7'b0000000, 3'b100}: aluOp = aluXor;
          {7'b0000000, 3'b101}: aluOp = aluSrl;
          {7'b0100000, 3'b101}: aluOp = aluSra;
          {7'b0000000, 3'b110}: aluOp = aluOr;
          {7'b0000000, 3'b111}: aluOp = aluAnd;
          default:              aluOp = aluAdd;
        endcase
      end
      opOp32: begin
        case ({func7, func3})
          {7'b0100000, 3'b000}: aluOp = aluSub;
          {7'b0000000, 3'b001}: aluOp = aluSllw;
          {7'b0000000, 3'b101}: aluOp = aluSrl;
          {7'b0100000, 3'b101}: aluOp = aluSra;
          default:              aluOp = aluAdd;
        endcase
      end
      default: aluOp = aluAdd;
    endcase
  end

  // store byte enables
  always_comb begin
    wmask = 8'h00;
    if (opcode == opStore) begin
      case (func3)
        3'b000:  wmask = 8'h01;
        3'b001:  wmask = 8'h03;
        3'b010:  wmask = 8'h0f;
        3'b011:  wmask = 8'hff;
        default: wmask = 8'h00;
      endcase
    end
  end

  assign wen       = (instType != typeS) && (instType != typeB) && (instType != typeBad);
  assign readFlag  = (opcode == opLoad);
  assign writeFlag = (opcode == opStore);
  assign jalrFlag  = (opcode == opJalr);
  assign wordOp    = (opcode == opOpImm32) || (opcode == opOp32);
  assign abort     = (instType == typeBad);

  // a bad instruction must never reach writeback
  wenNotAbort: assert property (@(posedge clock) disable iff (!rstN) !(wen && abort));

endmodule

`default_nettype wire

// File: hdl/operandSelect.sv
`timescale 1ns/10ps
`default_nettype none

module operandSelect import idPkg::*; (
  input  logic      clock,
  input  logic      rstN,
  input  word_t     rdata1,
  input  word_t     rdata2,
  input  word_t     passRdata,
  input  word_t     pc,
  input  word_t     imm,
  input  logic      busy1,
  input  logic      busy2,
  input  logic      pass1,
  input  logic      pass2,
  input  instType_t instType,
  input  opcode_t   opcode,
  input  aluOp_t    aluOp,
  input  logic [5:0] shamt,
  output word_t     src1,
  output word_t     src2,
  output word_t     rd1,
  output word_t     rd2
);

  logic  isShift;
  word_t lowZero;
  word_t lowSign;

  // bypass only when the scoreboard marks the source busy, so x0 reads stay zero
  assign src1 = (busy1 && pass1) ? passRdata : rdata1;
  assign src2 = (busy2 && pass2) ? passRdata : rdata2;

  assign isShift = aluOp inside {aluSll, aluSllw, aluSrl, aluSra};

  // word shifts see only the low half of rs1
  assign lowZero = {32'b0, src1[31:0]};
  assign lowSign = {{32{src1[31]}}, src1[31:0]};

  always_comb begin
    rd1 = '0;
    rd2 = '0;
    case (instType)
      typeI: begin
        if (opcode == opJalr) begin
          // link value pc + 4
          rd1 = pc;
          rd2 = 64'd4;
        end else if (isShift) begin
          rd2 = {58'b0, shamt};
          if (opcode == opOpImm32 && aluOp == aluSrl) begin
            rd1 = lowZero;
          end else if (opcode == opOpImm32 && aluOp == aluSra) begin
            rd1 = lowSign;
          end else begin
            rd1 = src1;
          end
        end else begin
          rd1 = src1;
          rd2 = imm;
        end
      end
      typeR: begin
        if (!isShift) begin
          rd1 = src1;
          rd2 = src2;
        end else if (opcode == opOp32) begin
          rd2 = {59'b0, src2[4:0]};
          rd1 = (aluOp == aluSrl) ? lowZero : (aluOp == aluSra) ? lowSign : src1;
        end else begin
          rd1 = src1;
          rd2 = {58'b0, src2[5:0]};
        end
      end
      typeS: begin
        rd1 = src1;
        rd2 = imm;
      end
      typeU: begin
        // lui adds to zero
        rd1 = (opcode == opAuipc) ? pc : '0;
        rd2 = imm;
      end
      typeJ: begin
        rd1 = pc;
        rd2 = 64'd4;
      end
      default: begin
        rd1 = '0;
        rd2 = '0;
      end
    endcase
  end

  idleSrc1: assert property (@(posedge clock) disable iff (!rstN) !busy1 |-> src1 == rdata1);

endmodule

`default_nettype wire

// File: hdl/branchResolve.sv
`timescale 1ns/10ps
`default_nettype none

module branchResolve import idPkg::*; (
  input  logic       clock,
  input  logic       rstN,
  input  word_t      src1,
  input  word_t      src2,
  input  instType_t  instType,
  input  opcode_t    opcode,
  input  logic [2:0] func3,
  output jumpKind_t  jumpKind
);

  logic equal;
  logic lessS;
  logic lessU;
  logic taken;

  assign equal = (src1 == src2);
  assign lessS = ($signed(src1) < $signed(src2));
  assign lessU = (src1 < src2);

  // condition from func3
  always_comb begin
    case (func3)
      3'b000:  taken = equal;
      3'b001:  taken = !equal;
      3'b100:  taken = lessS;
      3'b101:  taken = !lessS;
      3'b110:  taken = lessU;
      3'b111:  taken = !lessU;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (opcode == opJalr) begin
      jumpKind = jumpJalr;
    end else if (instType == typeB && taken) begin
      jumpKind = jumpBranch;
    end else if (opcode == opJal) begin
      jumpKind = jumpJal;
    end else begin
      jumpKind = jumpNone;
    end
  end

  branchOnlyB: assert property (@(posedge clock) disable iff (!rstN)
    jumpKind == jumpBranch |-> instType == typeB);

endmodule

`default_nettype wire

// File: hdl/issueControl.sv
`timescale 1ns/10ps
`default_nettype none

module issueControl (
  input  logic clock,
  input  logic rstN,
  input  logic busy1,
  input  logic busy2,
  input  logic pass1,
  input  logic pass2,
  input  logic ifValid,
  input  logic exReady,
  input  logic wen,
  output logic exValid,
  output logic ifReady,
  output logic scoreWen
);

  logic stall1;
  logic stall2;
  logic stall;

  // busy with no bypass means the producer has not finished
  assign stall1 = busy1 && !pass1;
  assign stall2 = busy2 && !pass2;
  assign stall  = stall1 || stall2;

  assign exValid  = ifValid && !stall;
  assign ifReady  = exReady && !stall;
  // reserve rd in the scoreboard once execute accepts
  assign scoreWen = exValid && wen && exReady;

  validNeedsFetch: assert property (@(posedge clock) disable iff (!rstN) exValid |-> ifValid);
  scoreNeedsIssue: assert property (@(posedge clock) disable iff (!rstN) scoreWen |-> exValid);

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import idPkg::*; (
  input  logic       clock,
  input  logic       rstN,
  input  inst_t      inst,
  input  word_t      pc,
  input  logic       ifValid,
  input  word_t      rdata1,
  input  word_t      rdata2,
  input  word_t      passRdata,
  input  logic       busy1,
  input  logic       busy2,
  input  logic       pass1,
  input  logic       pass2,
  input  logic       exReady,
  output regAddr_t   raddr1,
  output regAddr_t   raddr2,
  output regAddr_t   waddr,
  output logic       exValid,
  output word_t      exPc,
  output aluOp_t     aluOp,
  output word_t      rd1,
  output word_t      rd2,
  output word_t      imm,
  output word_t      rs2Data,
  output logic       wen,
  output logic       readFlag,
  output logic       writeFlag,
  output logic       jalrFlag,
  output logic       wordOp,
  output logic [7:0] wmask,
  output logic [2:0] func3,
  output logic       abort,
  output jumpKind_t  jumpKind,
  output word_t      npcPc,
  output word_t      npcImm,
  output word_t      npcRs1,
  output logic       ifReady,
  output logic       scoreWen
);

  opcode_t   opcode;
  instType_t instType;
  word_t     src1;
  word_t     src2;

  assign exPc    = pc;
  assign npcPc   = pc;
  assign npcImm  = imm;
  assign npcRs1  = src1;
  assign rs2Data = src2;

  instDecode uDecode (
    .clock(clock), .rstN(rstN), .inst(inst),
    .rs1(raddr1), .rs2(raddr2), .rd(waddr),
    .opcode(opcode), .instType(instType), .imm(imm), .aluOp(aluOp), .func3(func3),
    .wen(wen), .readFlag(readFlag), .writeFlag(writeFlag), .jalrFlag(jalrFlag),
    .wordOp(wordOp), .abort(abort), .wmask(wmask)
  );

  // immediate shifts take the shift amount from imm bits 5..0
  operandSelect uOperand (
    .clock(clock), .rstN(rstN),
    .rdata1(rdata1), .rdata2(rdata2), .passRdata(passRdata), .pc(pc), .imm(imm),
    .busy1(busy1), .busy2(busy2), .pass1(pass1), .pass2(pass2),
    .instType(instType), .opcode(opcode), .aluOp(aluOp), .shamt(imm[5:0]),
    .src1(src1), .src2(src2), .rd1(rd1), .rd2(rd2)
  );

  branchResolve uBranch (
    .clock(clock), .rstN(rstN), .src1(src1), .src2(src2),
    .instType(instType), .opcode(opcode), .func3(func3), .jumpKind(jumpKind)
  );

  issueControl uIssue (
    .clock(clock), .rstN(rstN),
    .busy1(busy1), .busy2(busy2), .pass1(pass1), .pass2(pass2),
    .ifValid(ifValid), .exReady(exReady), .wen(wen),
    .exValid(exValid), .ifReady(ifReady), .scoreWen(scoreWen)
  );

endmodule

`default_nettype wire

// File: bench/decodeStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb import idPkg::*; ();

  localparam int resetCycles = 4;
  localparam int fieldCount = 22;

  logic       clock;
  logic       rstN;
  inst_t      inst;
  word_t      pc;
  logic       ifValid;
  word_t      rdata1;
  word_t      rdata2;
  word_t      passRdata;
  logic       busy1;
  logic       busy2;
  logic       pass1;
  logic       pass2;
  logic       exReady;
  regAddr_t   raddr1;
  regAddr_t   raddr2;
  regAddr_t   waddr;
  logic       exValid;
  word_t      exPc;
  aluOp_t     aluOp;
  word_t      rd1;
  word_t      rd2;
  word_t      imm;
  word_t      rs2Data;
  logic       wen;
  logic       readFlag;
  logic       writeFlag;
  logic       jalrFlag;
  logic       wordOp;
  logic [7:0] wmask;
  logic [2:0] func3;
  logic       abort;
  jumpKind_t  jumpKind;
  word_t      npcPc;
  word_t      npcImm;
  word_t      npcRs1;
  logic       ifReady;
  logic       scoreWen;

  // expected results of the current vector
  logic [4:0] expOp;
  word_t      expRd1;
  word_t      expRd2;
  word_t      expImm;
  logic [7:0] expMask;
  logic       expWen;
  logic       expAbort;
  logic [3:0] expJump;
  logic       expExValid;
  logic       expIfReady;
  logic       expScoreWen;

  string lines[$];
  logic  fileOk;
  int    scanCount;
  int    vecErrors;
  int    passedVecs;
  int    failedVecs;
  int    cycleCount = 0;
  int    cycleLimit = resetCycles + 10;

  decodeStage UUT (
    .clock(clock), .rstN(rstN), .inst(inst), .pc(pc), .ifValid(ifValid),
    .rdata1(rdata1), .rdata2(rdata2), .passRdata(passRdata),
    .busy1(busy1), .busy2(busy2), .pass1(pass1), .pass2(pass2), .exReady(exReady),
    .raddr1(raddr1), .raddr2(raddr2), .waddr(waddr), .exValid(exValid), .exPc(exPc),
    .aluOp(aluOp), .rd1(rd1), .rd2(rd2), .imm(imm), .rs2Data(rs2Data),
    .wen(wen), .readFlag(readFlag), .writeFlag(writeFlag), .jalrFlag(jalrFlag),
    .wordOp(wordOp), .wmask(wmask), .func3(func3), .abort(abort),
    .jumpKind(jumpKind), .npcPc(npcPc), .npcImm(npcImm), .npcRs1(npcRs1),
    .ifReady(ifReady), .scoreWen(scoreWen)
  );

  always #50 clock = ~clock;

  // run guard counting rising edges
  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout after %0d cycles, the vectors did not finish", cycleCount);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      vecErrors++;
    end
  endtask

  task automatic checkOp(input aluOp_t got, input aluOp_t exp);
    if (got !== exp) begin
      $display("error at %0t: aluOp is %0d, expected %0d", $time, got, exp);
      vecErrors++;
    end
  endtask

  task automatic checkJump(input jumpKind_t got, input jumpKind_t exp);
    if (got !== exp) begin
      $display("error at %0t: jumpKind is %0d, expected %0d", $time, got, exp);
      vecErrors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      vecErrors++;
    end
  endtask

  task automatic checkAddr(input string name, input regAddr_t got, input regAddr_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      vecErrors++;
    end
  endtask

  // source value after the bypass merge
  function automatic word_t bypassValue(input logic busy, input logic pass,
                                        input word_t regData, input word_t bypassData);
    if (busy && pass) begin
      return bypassData;
    end else begin
      return regData;
    end
  endfunction

  // register fields, opcode flags and pass-through values
  task automatic checkSideOutputs();
    checkAddr("raddr1", raddr1, inst[19:15]);
    checkAddr("raddr2", raddr2, inst[24:20]);
    checkAddr("waddr", waddr, inst[11:7]);
    checkWord("func3", word_t'(func3), word_t'(inst[14:12]));
    checkFlag("readFlag", readFlag, inst[6:0] == opLoad);
    checkFlag("writeFlag", writeFlag, inst[6:0] == opStore);
    checkFlag("jalrFlag", jalrFlag, inst[6:0] == opJalr);
    checkFlag("wordOp", wordOp, (inst[6:0] == opOpImm32) || (inst[6:0] == opOp32));
    checkWord("exPc", exPc, pc);
    checkWord("npcPc", npcPc, pc);
    checkWord("npcImm", npcImm, expImm);
    checkWord("npcRs1", npcRs1, bypassValue(busy1, pass1, rdata1, passRdata));
    checkWord("rs2Data", rs2Data, bypassValue(busy2, pass2, rdata2, passRdata));
  endtask

  // keep data lines and skip lines that start with #
  task automatic loadVectors();
    int    fd;
    int    code;
    string line;
    fd = $fopen("bench/decodeVectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file bench/decodeVectors.txt");
      fileOk = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 1 && line.getc(0) != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
      if (lines.size() == 0) begin
        $display("the vector file holds no vectors");
        fileOk = 1'b0;
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    rstN = 1'b0;
    inst = '0;
    pc = '0;
    ifValid = 1'b0;
    rdata1 = '0;
    rdata2 = '0;
    passRdata = '0;
    busy1 = 1'b0;
    busy2 = 1'b0;
    pass1 = 1'b0;
    pass2 = 1'b0;
    exReady = 1'b0;
    fileOk = 1'b1;
    passedVecs = 0;
    failedVecs = 0;
    loadVectors();
    cycleLimit = resetCycles + lines.size() + 10;
    repeat (resetCycles) @(negedge clock);
    rstN = 1'b1;
    foreach (lines[i]) begin
      @(negedge clock);
      vecErrors = 0;
      scanCount = $sscanf(lines[i],
        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        inst, pc, rdata1, rdata2, passRdata, busy1, busy2, pass1, pass2, ifValid, exReady,
        expOp, expRd1, expRd2, expImm, expMask, expWen, expAbort, expJump,
        expExValid, expIfReady, expScoreWen);
      if (scanCount != fieldCount) begin
        $display("vector %0d is malformed, only %0d fields were read", i, scanCount);
        vecErrors = 1;
      end else begin
        // outputs settled half a period ago
        @(posedge clock);
        checkOp(aluOp, aluOp_t'(expOp));
        checkWord("rd1", rd1, expRd1);
        checkWord("rd2", rd2, expRd2);
        checkWord("imm", imm, expImm);
        checkWord("wmask", word_t'(wmask), word_t'(expMask));
        checkFlag("wen", wen, expWen);
        checkFlag("abort", abort, expAbort);
        checkJump(jumpKind, jumpKind_t'(expJump));
        checkFlag("exValid", exValid, expExValid);
        checkFlag("ifReady", ifReady, expIfReady);
        checkFlag("scoreWen", scoreWen, expScoreWen);
        checkSideOutputs();
      end
      if (vecErrors == 0) begin
        passedVecs++;
        $display("vector %0d ok", i);
      end else begin
        failedVecs++;
        $display("vector %0d failed with %0d mismatches", i, vecErrors);
      end
    end
    $display("%0d vectors run, %0d passed, %0d failed", lines.size(), passedVecs, failedVecs);
    if (fileOk && failedVecs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/decodeVectors.txt
# stimulus: inst pc rdata1 rdata2 passRdata busy1 busy2 pass1 pass2 ifValid exReady
# expected: aluOp rd1 rd2 imm wmask wen abort jumpKind exValid ifReady scoreWen (all hex)
FFB08193 1000 64 0 0 0 0 0 0 1 1 0 64 FFFFFFFFFFFFFFFB FFFFFFFFFFFFFFFB 0 1 0 0 1 1 1
FE20AA23 1000 64 7 0 0 0 0 0 1 1 0 64 FFFFFFFFFFFFFFF4 FFFFFFFFFFFFFFF4 f 0 0 0 1 1 0
00208863 1000 55 55 0 0 0 0 0 1 1 0 0 0 10 0 0 0 3 1 1 0
800011B7 1000 0 0 0 0 0 0 0 1 1 0 0 FFFFFFFF80001000 FFFFFFFF80001000 0 1 0 0 1 1 1
FF9FF1EF 1000 0 0 0 0 0 0 0 1 1 0 1000 4 FFFFFFFFFFFFFFF8 0 1 0 1 1 1 1
0F00C193 1000 0123456789ABCDEF 0 0 0 0 0 0 1 1 6 0123456789ABCDEF F0 F0 0 1 0 0 1 1 1
4280D193 1000 8000000000000000 0 0 0 0 0 0 1 1 8 8000000000000000 28 428 0 1 0 0 1 1 1
0050919B 1000 FFFFFFFF80000001 0 0 0 0 0 0 1 1 3 FFFFFFFF80000001 5 5 0 1 0 0 1 1 1
402081B3 1000 10 3 0 0 0 0 0 1 1 1 10 3 0 0 1 0 0 1 1 1
4020D1BB 1000 1234567887654321 3F 0 0 0 0 0 1 1 8 FFFFFFFF87654321 1F 0 0 1 0 0 1 1 1
0020B1B3 1000 1 2 0 0 0 0 0 1 1 5 1 2 0 0 1 0 0 1 1 1
00000073 1000 1 2 0 0 0 0 0 1 1 0 0 0 0 0 0 1 0 1 1 0
008081E7 1000 20 0 0 0 0 0 0 1 1 0 1000 4 8 0 1 0 2 1 1 1
12345197 1000 0 0 0 0 0 0 0 1 1 0 1000 12345000 12345000 0 1 0 0 1 1 1
4040D19B 1000 F0000000 0 0 0 0 0 0 1 1 8 FFFFFFFFF0000000 4 404 0 1 0 0 1 1 1
0020D1BB 1000 FFFFFFFF80000000 25 0 0 0 0 0 1 1 7 80000000 5 0 0 1 0 0 1 1 1
002081B3 1000 11 22 CAFEF00DDEADBEEF 1 0 1 0 1 1 0 CAFEF00DDEADBEEF 22 0 0 1 0 0 1 1 1
002081B3 1000 11 22 CAFEF00DDEADBEEF 1 0 0 0 1 1 0 11 22 0 0 1 0 0 0 0 0
00208863 1000 FFFFFFFFFFFFFFFF 1 0 0 0 0 0 1 1 0 0 0 10 0 0 0 0 1 1 0
FE209EE3 1000 FFFFFFFFFFFFFFFF 1 0 0 0 0 0 1 1 0 0 0 FFFFFFFFFFFFFFFC 0 0 0 3 1 1 0
0020C863 1000 FFFFFFFFFFFFFFFF 1 0 0 0 0 0 1 1 0 0 0 10 0 0 0 3 1 1 0
0020F863 1000 1 FFFFFFFFFFFFFFFF 0 0 0 0 0 1 1 0 0 0 10 0 0 0 0 1 1 0
FFB08193 1000 64 0 0 0 0 0 0 1 0 0 64 FFFFFFFFFFFFFFFB FFFFFFFFFFFFFFFB 0 1 0 0 1 0 0

// File: all.f
hdl/idPkg.sv
hdl/instDecode.sv
hdl/operandSelect.sv
hdl/branchResolve.sv
hdl/issueControl.sv
hdl/decodeStage.sv
bench/decodeStageTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
mkdir -p build && rm -f build/sim.log
verilator --binary --timing --assert -f all.f --top-module decodeStageTb -Mdir build/obj \
  && ./build/obj/VdecodeStageTb > build/sim.log 2>&1 \
  || echo "build or run stopped with an error"
cat build/sim.log 2>/dev/null
grep -q "SIMULATION PASSED" build/sim.log && echo "result: pass" \
  || { echo "result: fail"; exit 1; }
